/* Makefile */
TOP = dcache_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

obj_dir/V$(TOP): dcache.f $(wildcard rtl/*.sv verif/*.sv verif/*.svh)
	verilator --binary --timing -Wno-fatal -j 0 -f dcache.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -Wall -f dcache.f --top-module dcache_top

clean:
	rm -rf obj_dir

/* dcache.f */
+incdir+verif
rtl/dcache_pkg.sv
rtl/dcache_req_decode.sv
rtl/dcache_array.sv
rtl/dcache_miss_ctrl.sv
rtl/dcache_load_align.sv
rtl/dcache_top.sv
verif/dcache_tb.sv

/* rtl/dcache_array.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_array (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  dcache_pkg::addr_fields_t                i_fields,
    input  dcache_pkg::cpu_req_t                    i_req,
    input  wire logic                               i_store_en,
    input  wire logic                               i_fill_en,
    input  dcache_pkg::line_u                       i_fill_line,
    input  wire logic [dcache_pkg::WAY_W-1:0]       i_victim_way,
    output logic                                    o_hit,
    output dcache_pkg::line_u                       o_hit_line,
    output logic                                    o_victim_valid,
    output logic                                    o_victim_dirty,
    output logic [dcache_pkg::TAG_W-1:0]            o_victim_tag,
    output dcache_pkg::line_u                       o_victim_line
);

    logic [dcache_pkg::TAG_W-1:0] tag_q  [dcache_pkg::N_SETS][dcache_pkg::N_WAYS];
    dcache_pkg::line_u            data_q [dcache_pkg::N_SETS][dcache_pkg::N_WAYS];

    logic [dcache_pkg::N_SETS-1:0][dcache_pkg::N_WAYS-1:0] valid_q;
    logic [dcache_pkg::N_SETS-1:0][dcache_pkg::N_WAYS-1:0] dirty_q;

    logic [dcache_pkg::N_WAYS-1:0] match;
    logic [dcache_pkg::WAY_W-1:0]  hit_way;
    dcache_pkg::line_u             merged;
    logic [dcache_pkg::INDEX_W-1:0] idx;

    assign idx = i_fields.index;

    // tag compare across the set
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < dcache_pkg::N_WAYS; w++) begin
            match[w] = valid_q[idx][w] && (tag_q[idx][w] == i_fields.tag);
            if (match[w]) begin
                hit_way = w[dcache_pkg::WAY_W-1:0];
            end
        end
    end

    assign o_hit      = |match;
    assign o_hit_line = data_q[idx][hit_way];

    assign o_victim_valid = valid_q[idx][i_victim_way];
    assign o_victim_dirty = dirty_q[idx][i_victim_way];
    assign o_victim_tag   = tag_q[idx][i_victim_way];
    assign o_victim_line  = data_q[idx][i_victim_way];

    // store merge over the hit line
    always_comb begin
        merged = o_hit_line;
        case (i_req.size)
            dcache_pkg::SIZE_BYTE: begin
                merged.bytes[i_fields.offset] = i_req.wdata[7:0];
            end
            dcache_pkg::SIZE_HALF: begin
                merged.bytes[{i_fields.offset[dcache_pkg::OFFSET_W-1:1], 1'b0}] =
                    i_req.wdata[7:0];
                merged.bytes[{i_fields.offset[dcache_pkg::OFFSET_W-1:1], 1'b1}] =
                    i_req.wdata[15:8];
            end
            default: begin
                merged.words[i_fields.offset[dcache_pkg::OFFSET_W-1:2]] = i_req.wdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_fill_en) begin
            tag_q[idx][i_victim_way]  <= i_fields.tag;
            data_q[idx][i_victim_way] <= i_fill_line;
        end else if (i_store_en) begin
            data_q[idx][hit_way] <= merged;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (i_fill_en) begin
            valid_q[idx][i_victim_way] <= 1'b1;
            dirty_q[idx][i_victim_way] <= 1'b0;
        end else if (i_store_en) begin
            dirty_q[idx][hit_way] <= 1'b1;
        end
    end

    // a refill never duplicates a resident tag
    a_one_match : assert property (
        @(posedge clk) disable iff (rst) $onehot0(match)
    ) else $error("more than one way matches the tag");

endmodule

`default_nettype wire

/* rtl/dcache_load_align.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_load_align (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic                              i_load_hit,
    input  dcache_pkg::cpu_req_t                   i_req,
    input  wire logic [dcache_pkg::OFFSET_W-1:0]   i_offset,
    input  dcache_pkg::line_u                      i_line,
    output logic                                   o_rsp_valid,
    output dcache_pkg::cpu_rsp_t                   o_rsp
);

    logic [7:0]  byte_rd;
    logic [15:0] half_rd;
    logic [31:0] word_rd;
    logic [31:0] rdata;

    assign byte_rd = i_line.bytes[i_offset];
    assign half_rd = {i_line.bytes[{i_offset[dcache_pkg::OFFSET_W-1:1], 1'b1}],
                      i_line.bytes[{i_offset[dcache_pkg::OFFSET_W-1:1], 1'b0}]};
    assign word_rd = i_line.words[i_offset[dcache_pkg::OFFSET_W-1:2]];

    always_comb begin
        case (i_req.size)
            dcache_pkg::SIZE_BYTE: rdata = {{24{byte_rd[7] & !i_req.use_unsigned}}, byte_rd};
            dcache_pkg::SIZE_HALF: rdata = {{16{half_rd[15] & !i_req.use_unsigned}}, half_rd};
            default:               rdata = word_rd;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_rsp_valid <= 1'b0;
        end else begin
            o_rsp_valid <= i_load_hit; // one-cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (i_load_hit) begin
            o_rsp.rdata <= rdata;
        end
    end

endmodule

`default_nettype wire

/* rtl/dcache_miss_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_miss_ctrl (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           i_active,
    input  dcache_pkg::cpu_req_t                i_req,
    input  dcache_pkg::addr_fields_t            i_fields,
    input  wire logic                           i_hit,
    input  wire logic                           i_victim_valid,
    input  wire logic                           i_victim_dirty,
    input  wire logic [dcache_pkg::TAG_W-1:0]   i_victim_tag,
    input  dcache_pkg::line_u                   i_victim_line,
    output logic [dcache_pkg::WAY_W-1:0]        o_victim_way,
    output logic                                o_store_en,
    output logic                                o_fill_en,
    output logic                                o_done,
    output logic                                o_load_hit,
    output logic                                o_mem_req_valid,
    input  wire logic                           i_mem_req_ready,
    output dcache_pkg::mem_req_t                o_mem_req,
    input  wire logic                           i_mem_rsp_valid
);

    typedef enum logic [1:0] {
        LOOKUP,
        EVICT,
        REFILL_REQ,
        REFILL_WAIT
    } state_e;

    state_e                        state_q;
    state_e                        state_d;
    logic [7:0]                    lfsr_q;
    logic [dcache_pkg::WAY_W:0]    probe_q;  // top bit set: fall back to lfsr
    logic [dcache_pkg::WAY_W-1:0]  victim_q;
    logic                          miss;
    logic                          commit;

    assign miss   = (state_q == LOOKUP) && i_active && !i_hit;
    // stop scanning at the first invalid way
    assign commit = miss && (probe_q[dcache_pkg::WAY_W] || !i_victim_valid);

    always_comb begin
        if (state_q != LOOKUP) begin
            o_victim_way = victim_q;
        end else if (probe_q[dcache_pkg::WAY_W]) begin
            o_victim_way = lfsr_q[dcache_pkg::WAY_W-1:0];
        end else begin
            o_victim_way = probe_q[dcache_pkg::WAY_W-1:0];
        end
    end

    assign o_done     = (state_q == LOOKUP) && i_active && i_hit;
    assign o_store_en = o_done && i_req.store;
    assign o_load_hit = o_done && !i_req.store;
    assign o_fill_en  = (state_q == REFILL_WAIT) && i_mem_rsp_valid;

    always_comb begin
        state_d         = state_q;
        o_mem_req_valid = 1'b0;
        o_mem_req.write     = 1'b0;
        o_mem_req.line_addr = {i_fields.tag, i_fields.index};
        o_mem_req.data      = '0;
        case (state_q)
            LOOKUP: begin
                if (commit) begin
                    state_d = (i_victim_valid && i_victim_dirty) ? EVICT : REFILL_REQ;
                end
            end
            EVICT: begin
                o_mem_req_valid     = 1'b1;
                o_mem_req.write     = 1'b1;
                o_mem_req.line_addr = {i_victim_tag, i_fields.index};
                o_mem_req.data      = i_victim_line;
                if (i_mem_req_ready) begin
                    state_d = REFILL_REQ;
                end
            end
            REFILL_REQ: begin
                o_mem_req_valid = 1'b1;
                if (i_mem_req_ready) begin
                    state_d = REFILL_WAIT;
                end
            end
            REFILL_WAIT: begin
                if (i_mem_rsp_valid) begin
                    state_d = LOOKUP; // replay, now a hit
                end
            end
            default: state_d = LOOKUP;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q  <= LOOKUP;
            lfsr_q   <= dcache_pkg::LFSR_SEED;
            probe_q  <= '0;
            victim_q <= '0;
        end else begin
            state_q <= state_d;
            if (commit) begin
                victim_q <= o_victim_way;
                probe_q  <= '0;
                // galois, x^8+x^6+x^5+x^4+1
                lfsr_q   <= {1'b0, lfsr_q[7:1]} ^ (lfsr_q[0] ? 8'hB8 : 8'h00);
            end else if (miss) begin
                probe_q <= probe_q + 1'b1;
            end
        end
    end

    a_mem_req_stable : assert property (
        @(posedge clk) disable iff (rst)
        (o_mem_req_valid && !i_mem_req_ready) |=> (o_mem_req_valid && $stable(o_mem_req))
    ) else $error("memory request changed while stalled");

endmodule

`default_nettype wire

/* rtl/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    // geometry
    localparam int ADDR_W     = 16;
    localparam int N_SETS     = 4;
    localparam int N_WAYS     = 4;
    localparam int LINE_BYTES = 16;
    localparam int LINE_W     = LINE_BYTES * 8;
    localparam int OFFSET_W   = 4;
    localparam int INDEX_W    = 2;
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
    localparam int WAY_W      = 2;

    localparam logic [7:0] LFSR_SEED = 8'hA5; // must be nonzero

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_e;

    typedef struct packed {
        logic              store;
        size_e             size;
        logic              use_unsigned;
        logic [ADDR_W-1:0] addr;
        logic [31:0]       wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [31:0] rdata;
    } cpu_rsp_t;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } addr_fields_t;

    typedef struct packed {
        logic                      write;
        logic [TAG_W+INDEX_W-1:0]  line_addr; // tag and index
        logic [LINE_W-1:0]         data;
    } mem_req_t;

    typedef struct packed {
        logic [LINE_W-1:0] data;
    } mem_rsp_t;

    // word 0 holds bytes 0..3, little endian
    typedef union packed {
        logic [LINE_BYTES/4-1:0][31:0] words;
        logic [LINE_BYTES-1:0][7:0]    bytes;
    } line_u;

endpackage

`default_nettype wire

/* rtl/dcache_req_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_req_decode (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     i_req_valid,
    output logic                          o_req_ready,
    input  dcache_pkg::cpu_req_t          i_req,
    input  wire logic                     i_done,
    output logic                          o_active,
    output dcache_pkg::cpu_req_t          o_req,
    output dcache_pkg::addr_fields_t      o_fields
);

    logic                 active_q;
    dcache_pkg::cpu_req_t req_q;
    logic                 accept;

    assign accept      = i_req_valid && o_req_ready;
    assign o_req_ready = !active_q; // one request at a time
    assign o_active    = active_q;
    assign o_req       = req_q;
    assign o_fields    = dcache_pkg::addr_fields_t'(req_q.addr);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active_q <= 1'b0;
        end else if (accept) begin
            active_q <= 1'b1;
        end else if (i_done) begin
            active_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= i_req;
        end
    end

    // natural alignment only
    a_aligned : assert property (
        @(posedge clk) disable iff (rst)
        accept |-> ((i_req.size == dcache_pkg::SIZE_HALF) ? !i_req.addr[0] :
                    (i_req.size == dcache_pkg::SIZE_WORD) ? (i_req.addr[1:0] == 2'b00) :
                    (i_req.size == dcache_pkg::SIZE_BYTE))
    ) else $error("misaligned or bad-size request accepted");

endmodule

`default_nettype wire

/* rtl/dcache_top.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_top (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 i_req_valid,
    output logic                      o_req_ready,
    input  dcache_pkg::cpu_req_t      i_req,
    output logic                      o_rsp_valid,
    output dcache_pkg::cpu_rsp_t      o_rsp,
    output logic                      o_mem_req_valid,
    input  wire logic                 i_mem_req_ready,
    output dcache_pkg::mem_req_t      o_mem_req,
    input  wire logic                 i_mem_rsp_valid,
    input  dcache_pkg::mem_rsp_t      i_mem_rsp
);

    logic                           active;
    logic                           done;
    logic                           load_hit;
    dcache_pkg::cpu_req_t           req;
    dcache_pkg::addr_fields_t       fields;
    logic                           hit;
    dcache_pkg::line_u              hit_line;
    logic                           victim_valid;
    logic                           victim_dirty;
    logic [dcache_pkg::TAG_W-1:0]   victim_tag;
    dcache_pkg::line_u              victim_line;
    logic [dcache_pkg::WAY_W-1:0]   victim_way;
    logic                           store_en;
    logic                           fill_en;

    dcache_req_decode req_decode_i (
        .clk         (clk),
        .rst         (rst),
        .i_req_valid (i_req_valid),
        .o_req_ready (o_req_ready),
        .i_req       (i_req),
        .i_done      (done),
        .o_active    (active),
        .o_req       (req),
        .o_fields    (fields)
    );

    dcache_array array_i (
        .clk            (clk),
        .rst            (rst),
        .i_fields       (fields),
        .i_req          (req),
        .i_store_en     (store_en),
        .i_fill_en      (fill_en),
        .i_fill_line    (i_mem_rsp.data),
        .i_victim_way   (victim_way),
        .o_hit          (hit),
        .o_hit_line     (hit_line),
        .o_victim_valid (victim_valid),
        .o_victim_dirty (victim_dirty),
        .o_victim_tag   (victim_tag),
        .o_victim_line  (victim_line)
    );

    dcache_miss_ctrl miss_ctrl_i (
        .clk             (clk),
        .rst             (rst),
        .i_active        (active),
        .i_req           (req),
        .i_fields        (fields),
        .i_hit           (hit),
        .i_victim_valid  (victim_valid),
        .i_victim_dirty  (victim_dirty),
        .i_victim_tag    (victim_tag),
        .i_victim_line   (victim_line),
        .o_victim_way    (victim_way),
        .o_store_en      (store_en),
        .o_fill_en       (fill_en),
        .o_done          (done),
        .o_load_hit      (load_hit),
        .o_mem_req_valid (o_mem_req_valid),
        .i_mem_req_ready (i_mem_req_ready),
        .o_mem_req       (o_mem_req),
        .i_mem_rsp_valid (i_mem_rsp_valid)
    );

    dcache_load_align load_align_i (
        .clk         (clk),
        .rst         (rst),
        .i_load_hit  (load_hit),
        .i_req       (req),
        .i_offset    (fields.offset),
        .i_line      (hit_line),
        .o_rsp_valid (o_rsp_valid),
        .o_rsp       (o_rsp)
    );

endmodule

`default_nettype wire

/* verif/dcache_tb_model.svh */
`ifndef DCACHE_TB_MODEL_SVH
`define DCACHE_TB_MODEL_SVH

// side 0 is what memory holds, side 1 has every store applied at acceptance
localparam int MEM_SIDE = 0;
localparam int REF_SIDE = 1;

logic [7:0]  mem_bytes [2][65536];
logic [31:0] rng_state = 32'd93913;

function automatic logic [7:0] init_byte(input logic [15:0] a);
    return a[7:0] ^ (a[15:8] * 8'd29) ^ 8'h6b;
endfunction

// galois lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
        v         = {v[30:0], rng_state[0]};
        rng_state = lfsr_next(rng_state);
    end
endtask

function automatic int access_bytes(input dcache_pkg::size_e s);
    case (s)
        dcache_pkg::SIZE_BYTE: return 1;
        dcache_pkg::SIZE_HALF: return 2;
        default:               return 4;
    endcase
endfunction

function automatic logic [127:0] read_line(input int side, input logic [11:0] la);
    logic [127:0] line;
    for (int i = 0; i < 16; i++) begin
        line[8*i +: 8] = mem_bytes[side][{la, i[3:0]}]; // byte 0 lowest
    end
    return line;
endfunction

function automatic dcache_pkg::cpu_rsp_t expect_load(input dcache_pkg::cpu_req_t r);
    dcache_pkg::cpu_rsp_t rsp;
    int                   n;
    n   = access_bytes(r.size);
    rsp = '0;
    for (int i = 0; i < n; i++) begin
        rsp.rdata[8*i +: 8] = mem_bytes[REF_SIDE][r.addr + 16'(i)];
    end
    if (!r.use_unsigned) begin
        for (int b = 8 * n; b < 32; b++) begin
            rsp.rdata[b] = rsp.rdata[8*n-1]; // sign fill
        end
    end
    return rsp;
endfunction

task automatic end_with_error(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at first error");
endtask

task automatic check_rsp(input dcache_pkg::cpu_rsp_t got, input dcache_pkg::cpu_rsp_t want);
    if (got !== want) begin
        end_with_error($sformatf("Mismatch at %0t: o_rsp.rdata got %h expected %h",
                                 $time, got.rdata, want.rdata));
    end
endtask

task automatic check_mem_write(input dcache_pkg::mem_req_t got, input dcache_pkg::mem_req_t want);
    if (got !== want) begin
        end_with_error($sformatf("Mismatch at %0t: o_mem_req got %h expected %h",
                                 $time, got, want));
    end
endtask

`endif

/* verif/dcache_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_tb;

    localparam int N_OPS      = 600;
    localparam int MAX_CYCLES = N_OPS * 60;

    logic                 clk;
    logic                 rst;
    logic                 i_req_valid;
    logic                 o_req_ready;
    dcache_pkg::cpu_req_t i_req;
    logic                 o_rsp_valid;
    dcache_pkg::cpu_rsp_t o_rsp;
    logic                 o_mem_req_valid;
    logic                 i_mem_req_ready;
    dcache_pkg::mem_req_t o_mem_req;
    logic                 i_mem_rsp_valid;
    dcache_pkg::mem_rsp_t i_mem_rsp;

    dcache_pkg::cpu_rsp_t exp_q [$]; // loads in flight in issue order
    dcache_pkg::mem_req_t held_req;
    bit                   touched [4096];
    bit                   dirty_line [4096]; // stored to since the last write-back
    logic [11:0]          cur_line;
    bit                   running;
    bit                   stalled;
    bit                   need_read;
    bit                   read_seen;
    bit                   read_pending;
    int                   cycles;
    int                   n_ops;
    int                   n_hits;
    int                   n_writebacks;
    int                   load_acc;
    int                   rsp_delay;

    `include "dcache_tb_model.svh"

    dcache_top dut_i (.*);

    always #20 clk = !clk;

    initial begin
        clk             = 1'b0;
        rst             = 1'b1;
        i_req_valid     = 1'b0;
        i_req           = '0;
        i_mem_req_ready = 1'b0;
        i_mem_rsp_valid = 1'b0;
        i_mem_rsp       = '0;
        for (int a = 0; a < 65536; a++) begin
            mem_bytes[MEM_SIDE][a] = init_byte(16'(a));
            mem_bytes[REF_SIDE][a] = init_byte(16'(a));
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (!o_req_ready || o_rsp_valid || o_mem_req_valid) begin
            end_with_error("outputs are not idle after reset");
        end
        @(posedge clk);
        running = 1'b1;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            end_with_error($sformatf("timeout after %0d cycles, %0d of %0d operations issued",
                                     cycles, n_ops, N_OPS));
        end
    end

    // memory side first, then responses, then the next request
    always @(negedge clk) begin
        if (running) begin
            serve_memory();
            check_response();
            drive_request();
        end
    end

    task automatic serve_memory();
        dcache_pkg::mem_req_t want;
        logic [31:0]          r;
        i_mem_rsp_valid = 1'b0;
        if (read_pending && rsp_delay == 0) begin
            i_mem_rsp_valid = 1'b1;
            i_mem_rsp.data  = read_line(MEM_SIDE, cur_line);
            read_pending    = 1'b0;
        end else if (read_pending) begin
            rsp_delay--;
        end
        if (stalled && (!o_mem_req_valid || o_mem_req !== held_req)) begin
            end_with_error($sformatf("at %0t the memory request changed while stalled", $time));
        end
        take_bits(2, r);
        i_mem_req_ready = (r[1:0] != 2'b00);
        stalled         = o_mem_req_valid && !i_mem_req_ready;
        held_req        = o_mem_req;
        if (o_mem_req_valid && i_mem_req_ready && o_mem_req.write) begin
            if (!dirty_line[o_mem_req.line_addr]) begin
                end_with_error($sformatf("at %0t a write-back of clean line %h",
                                         $time, o_mem_req.line_addr));
            end
            want.write     = 1'b1;
            want.line_addr = {o_mem_req.line_addr[11:2], cur_line[1:0]};
            want.data      = read_line(REF_SIDE, want.line_addr);
            check_mem_write(o_mem_req, want);
            dirty_line[o_mem_req.line_addr] = 1'b0;
            for (int i = 0; i < 16; i++) begin
                mem_bytes[MEM_SIDE][{o_mem_req.line_addr, i[3:0]}] = o_mem_req.data[8*i +: 8];
            end
            n_writebacks++;
        end else if (o_mem_req_valid && i_mem_req_ready) begin
            if (read_pending) begin
                end_with_error($sformatf("at %0t a second memory read came before the response",
                                         $time));
            end else if (o_mem_req.line_addr !== cur_line) begin
                end_with_error($sformatf("Mismatch at %0t: o_mem_req.line_addr got %h expected %h",
                                         $time, o_mem_req.line_addr, cur_line));
            end
            read_pending = 1'b1;
            read_seen    = 1'b1;
            take_bits(3, r);
            rsp_delay = int'(r[2:0]); // 0 to 7 cycles
        end
    endtask

    task automatic check_response();
        if (o_rsp_valid && exp_q.size() == 0) begin
            end_with_error($sformatf("at %0t a response came with no load outstanding", $time));
        end else if (o_rsp_valid && !read_seen && cycles != load_acc + 1) begin
            // a hit is raised by the edge right after acceptance
            end_with_error($sformatf("at %0t a load hit answered %0d edges after acceptance",
                                     $time, cycles - load_acc + 1));
        end else if (o_rsp_valid) begin
            n_hits += read_seen ? 0 : 1;
            check_rsp(o_rsp, exp_q.pop_front());
        end
    endtask

    task automatic drive_request();
        dcache_pkg::cpu_req_t req;
        logic [31:0]          r;
        i_req_valid = 1'b0;
        if (o_req_ready && need_read && !read_seen) begin
            end_with_error($sformatf("first access to line %h finished with no memory read",
                                     cur_line));
        end else if (o_req_ready && n_ops < N_OPS) begin
            take_bits(4, r);
            req.store        = r[0];
            req.use_unsigned = r[1];
            req.size         = (r[3:2] == 2'd0) ? dcache_pkg::SIZE_BYTE :
                               (r[3:2] == 2'd1) ? dcache_pkg::SIZE_HALF : dcache_pkg::SIZE_WORD;
            take_bits(9, r);
            // 8 tags per set spread over the tag field
            req.addr = {10'(r[8:6]) * 10'd73, r[5:0]} & ~16'(access_bytes(req.size) - 1);
            take_bits(32, r);
            req.wdata   = r;
            i_req_valid = 1'b1;
            i_req       = req;
            cur_line    = req.addr[15:4];
            need_read   = !touched[cur_line];
            read_seen   = 1'b0;
            touched[cur_line] = 1'b1;
            if (req.store) begin
                for (int i = 0; i < access_bytes(req.size); i++) begin
                    mem_bytes[REF_SIDE][req.addr + 16'(i)] = req.wdata[8*i +: 8];
                end
                dirty_line[cur_line] = 1'b1;
            end else begin
                exp_q.push_back(expect_load(req));
                load_acc = cycles + 1;
            end
            n_ops++;
        end else if (o_req_ready && exp_q.size() == 0 && n_hits > 0 && n_writebacks > 0) begin
            $display("%0d operations, %0d load hits, %0d write-backs", n_ops, n_hits, n_writebacks);
            $display(">>> PASS");
            $finish;
        end else if (o_req_ready) begin
            end_with_error($sformatf("run ended with %0d loads unanswered, %0d hits, %0d write-backs",
                                     exp_q.size(), n_hits, n_writebacks));
        end
    endtask

endmodule

`default_nettype wire
